// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
LOG       ?= sim.log
FILELIST  ?= mem_subsys.f
OBJ_DIR   ?= obj_dir

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) mem_defs.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --timescale 1ns/1ps \
		-f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: byte_counter.sv
`timescale 1ns/1ps

module byte_counter import mem_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_i,
    input  logic      clear_i,
    input  logic      en_i,
    input  data_len_t len_i,
    input  logic      load_i,
    output byte_idx_t byte_idx_o,
    output byte_idx_t prev_idx_o,
    output logic      last_o
);

    byte_idx_t idx_q;
    byte_idx_t prev_q;
    data_len_t len_q;
    data_len_t last_idx;

    always_ff @(posedge clk_in)
    begin
        if (rst_i)
        begin
            idx_q  <= '0;
            prev_q <= '0;
            len_q  <= '0;
        end
        else
        begin
            if (load_i)
            begin
                len_q <= len_i;
            end
            if (clear_i)
            begin
                idx_q  <= '0;
                prev_q <= '0;
            end
            else if (en_i)
            begin
                // previous index drives the read capture slot
                prev_q <= idx_q;
                idx_q  <= idx_q + 2'd1;
            end
        end
    end

    assign last_idx   = len_q - 3'd1;
    assign last_o     = ({1'b0, idx_q} == last_idx);
    assign byte_idx_o = idx_q;
    assign prev_idx_o = prev_q;

endmodule

// File: byte_lane_unit.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module byte_lane_unit import mem_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_i,
    input  logic      latch_i,
    input  word_t     addr_i,
    input  word_t     wdata_i,
    input  byte_idx_t byte_idx_i,
    input  byte_idx_t cap_idx_i,
    input  logic      cap_en_i,
    input  byte_t     ram_rdata_i,
    output ram_addr_t ram_addr_o,
    output byte_t     ram_wdata_o,
    output word_t     read_word_o
);

    ram_addr_t base_q;
    word_t     wdata_q;
    word_t     word_q;

    always_ff @(posedge clk_in)
    begin
        if (latch_i)
        begin
            base_q  <= addr_i[`RAM_ADDR_W-1:0];
            wdata_q <= wdata_i;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_i || latch_i)
        begin
            word_q <= '0;
        end
        else if (cap_en_i)
        begin
            word_q[{cap_idx_i, 3'b000} +: 8] <= ram_rdata_i;
        end
    end

    // little endian, byte 0 at the base address
    assign ram_addr_o  = base_q + {{(`RAM_ADDR_W-2){1'b0}}, byte_idx_i};
    assign ram_wdata_o = wdata_q[{byte_idx_i, 3'b000} +: 8];
    assign read_word_o = word_q;

endmodule

// File: byte_ram.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module byte_ram import mem_pkg::*; (
    input  logic      clk_in,
    input  logic      we_i,
    input  ram_addr_t addr_i,
    input  byte_t     wdata_i,
    output byte_t     rdata_o
);

    byte_t mem_q [0:(1 << `RAM_ADDR_W)-1];

    initial
    begin
        for (int i = 0; i < (1 << `RAM_ADDR_W); i++)
        begin
            mem_q[i] = '0;
        end
    end

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk_in)
    begin
        if (we_i)
        begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];
    end

endmodule

// File: mem_ctrl_fsm.sv
`timescale 1ns/1ps

module mem_ctrl_fsm import mem_pkg::*; (
    input  logic clk_in,
    input  logic rst_i,
    input  logic read_req_i,
    input  logic write_req_i,
    input  logic cnt_last_i,
    output logic ctrl_busy_o,
    output logic load_done_o,
    output logic latch_req_o,
    output logic cnt_clear_o,
    output logic cnt_en_o,
    output logic cap_en_o,
    output logic ram_we_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    // extra read cycle after the last address
    logic        rd_tail_q;
    // a byte address went out last cycle
    logic        cap_pend_q;

    always_ff @(posedge clk_in)
    begin
        if (rst_i)
        begin
            state_q    <= IDLE;
            rd_tail_q  <= 1'b0;
            cap_pend_q <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            rd_tail_q  <= (state_q == READ) && !rd_tail_q && cnt_last_i;
            cap_pend_q <= (state_q == READ) && !rd_tail_q;
        end
    end

    always_comb
    begin
        state_d     = state_q;
        ctrl_busy_o = 1'b0;
        load_done_o = 1'b0;
        latch_req_o = 1'b0;
        cnt_clear_o = 1'b0;
        cnt_en_o    = 1'b0;
        cap_en_o    = 1'b0;
        ram_we_o    = 1'b0;
        case (state_q)
            IDLE:
            begin
                if (read_req_i || write_req_i)
                begin
                    latch_req_o = 1'b1;
                    cnt_clear_o = 1'b1;
                    state_d     = read_req_i ? READ : WRITE;
                end
            end
            READ:
            begin
                ctrl_busy_o = 1'b1;
                cap_en_o    = cap_pend_q;
                if (rd_tail_q)
                begin
                    state_d = DONE;
                end
                else
                begin
                    cnt_en_o = 1'b1;
                end
            end
            WRITE:
            begin
                ctrl_busy_o = 1'b1;
                ram_we_o    = 1'b1;
                cnt_en_o    = 1'b1;
                if (cnt_last_i)
                begin
                    state_d = DONE;
                end
            end
            DONE:
            begin
                load_done_o = 1'b1;
                cnt_clear_o = 1'b1;
                state_d     = IDLE;
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

// File: mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// access kinds seen by the memory stage
`define CMD_NONE 4'd0
`define CMD_LB   4'd1
`define CMD_LH   4'd2
`define CMD_LW   4'd3
`define CMD_LBU  4'd4
`define CMD_LHU  4'd5
`define CMD_SB   4'd6
`define CMD_SH   4'd7
`define CMD_SW   4'd8

// 4 KiB byte RAM
`define RAM_ADDR_W 12

// byte counts per access
`define LEN_BYTE 3'd1
`define LEN_HALF 3'd2
`define LEN_WORD 3'd4

`define WORD_ZERO 32'h0000_0000
`define REG_ZERO  5'd0
`define LEN_ZERO  3'd0

`endif

// File: mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // one RAM location
    typedef logic [7:0] byte_t;

    // destination register index
    typedef logic [4:0] reg_addr_t;

    typedef logic [3:0] cmd_t;

    // byte count of one access, 0 to 4
    typedef logic [2:0] data_len_t;

    // byte position inside a word
    typedef logic [1:0] byte_idx_t;

    typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DONE
    } ctrl_state_e;

endpackage

// File: mem_stage.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage import mem_pkg::*; (
    input  logic      rst_i,
    input  cmd_t      cmd_i,
    input  word_t     mem_addr_i,
    input  word_t     store_data_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     rd_data_i,
    input  logic      rd_we_i,
    input  logic      load_done_i,
    input  logic      ctrl_busy_i,
    input  word_t     read_word_i,
    output reg_addr_t wb_rd_addr_o,
    output word_t     wb_rd_data_o,
    output logic      wb_we_o,
    output logic      fwd_valid_o,
    output reg_addr_t fwd_addr_o,
    output word_t     fwd_data_o,
    output logic      stall_o,
    output logic      read_req_o,
    output logic      write_req_o,
    output word_t     req_addr_o,
    output word_t     req_wdata_o,
    output data_len_t req_len_o
);

    logic      is_load;
    logic      is_store;
    data_len_t cmd_len;

    always_comb
    begin
        is_load  = 1'b0;
        is_store = 1'b0;
        cmd_len  = `LEN_ZERO;
        case (cmd_i)
            `CMD_LB, `CMD_LBU:
            begin
                is_load = 1'b1;
                cmd_len = `LEN_BYTE;
            end
            `CMD_LH, `CMD_LHU:
            begin
                is_load = 1'b1;
                cmd_len = `LEN_HALF;
            end
            `CMD_LW:
            begin
                is_load = 1'b1;
                cmd_len = `LEN_WORD;
            end
            `CMD_SB:
            begin
                is_store = 1'b1;
                cmd_len  = `LEN_BYTE;
            end
            `CMD_SH:
            begin
                is_store = 1'b1;
                cmd_len  = `LEN_HALF;
            end
            `CMD_SW:
            begin
                is_store = 1'b1;
                cmd_len  = `LEN_WORD;
            end
            default:
            begin
                cmd_len = `LEN_ZERO;
            end
        endcase
    end

    always_comb
    begin
        wb_rd_addr_o = `REG_ZERO;
        wb_rd_data_o = `WORD_ZERO;
        wb_we_o      = 1'b0;
        stall_o      = 1'b0;
        read_req_o   = 1'b0;
        write_req_o  = 1'b0;
        req_addr_o   = `WORD_ZERO;
        req_wdata_o  = `WORD_ZERO;
        req_len_o    = `LEN_ZERO;
        if (!rst_i)
        begin
            wb_rd_addr_o = rd_addr_i;
            wb_rd_data_o = rd_data_i;
            wb_we_o      = rd_we_i;
            if (load_done_i)
            begin
                // extend the assembled word per command
                case (cmd_i)
                    `CMD_LB:  wb_rd_data_o = {{24{read_word_i[7]}}, read_word_i[7:0]};
                    `CMD_LH:  wb_rd_data_o = {{16{read_word_i[15]}}, read_word_i[15:0]};
                    `CMD_LW:  wb_rd_data_o = read_word_i;
                    `CMD_LBU: wb_rd_data_o = {24'h0, read_word_i[7:0]};
                    `CMD_LHU: wb_rd_data_o = {16'h0, read_word_i[15:0]};
                    default:  wb_rd_data_o = rd_data_i;
                endcase
            end
            else if (is_load || is_store)
            begin
                stall_o     = 1'b1;
                req_addr_o  = mem_addr_i;
                req_wdata_o = is_store ? store_data_i : `WORD_ZERO;
                // controller already working on this access
                if (!ctrl_busy_i)
                begin
                    read_req_o  = is_load;
                    write_req_o = is_store;
                    req_len_o   = cmd_len;
                end
            end
        end
        fwd_valid_o = wb_we_o;
        fwd_addr_o  = wb_we_o ? wb_rd_addr_o : `REG_ZERO;
        fwd_data_o  = wb_we_o ? wb_rd_data_o : `WORD_ZERO;
    end

endmodule

// File: mem_subsys.f
+incdir+.
mem_pkg.sv
mem_stage.sv
mem_ctrl_fsm.sv
byte_counter.sv
byte_lane_unit.sv
byte_ram.sv
mem_subsys.sv
tb_clock_gen.sv
mem_subsys_assertions.sv
tb_mem_subsys.sv

// File: mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys import mem_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_i,
    input  cmd_t      cmd_i,
    input  word_t     mem_addr_i,
    input  word_t     store_data_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     rd_data_i,
    input  logic      rd_we_i,
    output reg_addr_t wb_rd_addr_o,
    output word_t     wb_rd_data_o,
    output logic      wb_we_o,
    output logic      fwd_valid_o,
    output reg_addr_t fwd_addr_o,
    output word_t     fwd_data_o,
    output logic      stall_o
);

    logic      read_req;
    logic      write_req;
    word_t     req_addr;
    word_t     req_wdata;
    data_len_t req_len;
    logic      ctrl_busy;
    logic      load_done;
    word_t     read_word;
    logic      cnt_clear;
    logic      cnt_en;
    logic      latch_req;
    logic      cap_en;
    logic      ram_we;
    logic      cnt_last;
    byte_idx_t byte_idx;
    byte_idx_t cap_idx;
    ram_addr_t ram_addr;
    byte_t     ram_wdata;
    byte_t     ram_rdata;

    mem_stage u_stage (
        .rst_i        (rst_i),
        .cmd_i        (cmd_i),
        .mem_addr_i   (mem_addr_i),
        .store_data_i (store_data_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_i    (rd_data_i),
        .rd_we_i      (rd_we_i),
        .load_done_i  (load_done),
        .ctrl_busy_i  (ctrl_busy),
        .read_word_i  (read_word),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_rd_data_o (wb_rd_data_o),
        .wb_we_o      (wb_we_o),
        .fwd_valid_o  (fwd_valid_o),
        .fwd_addr_o   (fwd_addr_o),
        .fwd_data_o   (fwd_data_o),
        .stall_o      (stall_o),
        .read_req_o   (read_req),
        .write_req_o  (write_req),
        .req_addr_o   (req_addr),
        .req_wdata_o  (req_wdata),
        .req_len_o    (req_len)
    );

    mem_ctrl_fsm u_fsm (
        .clk_in      (clk_in),
        .rst_i       (rst_i),
        .read_req_i  (read_req),
        .write_req_i (write_req),
        .cnt_last_i  (cnt_last),
        .ctrl_busy_o (ctrl_busy),
        .load_done_o (load_done),
        .latch_req_o (latch_req),
        .cnt_clear_o (cnt_clear),
        .cnt_en_o    (cnt_en),
        .cap_en_o    (cap_en),
        .ram_we_o    (ram_we)
    );

    byte_counter u_counter (
        .clk_in     (clk_in),
        .rst_i      (rst_i),
        .clear_i    (cnt_clear),
        .en_i       (cnt_en),
        .len_i      (req_len),
        .load_i     (latch_req),
        .byte_idx_o (byte_idx),
        .prev_idx_o (cap_idx),
        .last_o     (cnt_last)
    );

    byte_lane_unit u_lanes (
        .clk_in      (clk_in),
        .rst_i       (rst_i),
        .latch_i     (latch_req),
        .addr_i      (req_addr),
        .wdata_i     (req_wdata),
        .byte_idx_i  (byte_idx),
        .cap_idx_i   (cap_idx),
        .cap_en_i    (cap_en),
        .ram_rdata_i (ram_rdata),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .read_word_o (read_word)
    );

    byte_ram u_ram (
        .clk_in  (clk_in),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: mem_subsys_assertions.sv
`timescale 1ns/1ps

module mem_subsys_assertions import mem_pkg::*; (
    input logic        clk_in,
    input logic        rst_i,
    input logic        load_done_i,
    input logic        read_req_i,
    input logic        write_req_i,
    input logic        ctrl_busy_i,
    input logic        stall_i,
    input ctrl_state_e state_i
);

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk_in) disable iff (rst_i)
        load_done_i |=> !load_done_i)
        else $error("load_done stayed high for two cycles");

    a_no_req_busy: assert property (@(posedge clk_in) disable iff (rst_i)
        ctrl_busy_i |-> !(read_req_i || write_req_i))
        else $error("request raised while the controller is busy");

    // write-back data is final in DONE
    a_no_stall_done: assert property (@(posedge clk_in) disable iff (rst_i)
        (state_i == DONE) |-> !stall_i)
        else $error("stall_o high while the FSM is in DONE");

endmodule

bind mem_subsys mem_subsys_assertions u_assertions (
    .clk_in      (clk_in),
    .rst_i       (rst_i),
    .load_done_i (load_done),
    .read_req_i  (read_req),
    .write_req_i (write_req),
    .ctrl_busy_i (ctrl_busy),
    .stall_i     (stall_o),
    .state_i     (u_fsm.state_q)
);

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_subsys import mem_pkg::*; ();

    localparam int NUM_OPS       = 400;
    localparam int NUM_DIRECTED  = 10;
    localparam int MAX_OP_CYCLES = 8;
    localparam int CYCLE_LIMIT   = NUM_OPS * MAX_OP_CYCLES + 20;

    logic      clk_in;
    logic      rst_i;
    cmd_t      cmd_i;
    word_t     mem_addr_i;
    word_t     store_data_i;
    reg_addr_t rd_addr_i;
    word_t     rd_data_i;
    logic      rd_we_i;
    reg_addr_t wb_rd_addr_o;
    word_t     wb_rd_data_o;
    logic      wb_we_o;
    logic      fwd_valid_o;
    reg_addr_t fwd_addr_o;
    word_t     fwd_data_o;
    logic      stall_o;

    logic [31:0] rng_state;
    byte_t       model_mem [0:(1 << `RAM_ADDR_W)-1];
    int          cycle_count;

    tb_clock_gen u_clk (
        .clk_o (clk_in)
    );

    mem_subsys UUT (
        .clk_in       (clk_in),
        .rst_i        (rst_i),
        .cmd_i        (cmd_i),
        .mem_addr_i   (mem_addr_i),
        .store_data_i (store_data_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_i    (rd_data_i),
        .rd_we_i      (rd_we_i),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_rd_data_o (wb_rd_data_o),
        .wb_we_o      (wb_we_o),
        .fwd_valid_o  (fwd_valid_o),
        .fwd_addr_o   (fwd_addr_o),
        .fwd_data_o   (fwd_data_o),
        .stall_o      (stall_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output word_t r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic int cmd_bytes(input cmd_t cmd);
        case (cmd)
            `CMD_LB, `CMD_LBU, `CMD_SB: return 1;
            `CMD_LH, `CMD_LHU, `CMD_SH: return 2;
            `CMD_LW, `CMD_SW:           return 4;
            default:                    return 0;
        endcase
    endfunction

    function automatic logic is_load(input cmd_t cmd);
        return (cmd == `CMD_LB) || (cmd == `CMD_LH) || (cmd == `CMD_LW) ||
               (cmd == `CMD_LBU) || (cmd == `CMD_LHU);
    endfunction

    function automatic logic is_store(input cmd_t cmd);
        return (cmd == `CMD_SB) || (cmd == `CMD_SH) || (cmd == `CMD_SW);
    endfunction

    // little endian, sign taken from the top loaded byte
    function automatic word_t model_load(input cmd_t cmd, input word_t addr);
        word_t val;
        int    n;
        int    i;
        val = '0;
        n = cmd_bytes(cmd);
        for (i = 0; i < n; i++)
        begin
            val[8*i +: 8] = model_mem[ram_addr_t'(addr + i)];
        end
        if (((cmd == `CMD_LB) || (cmd == `CMD_LH)) && val[8*n-1])
        begin
            for (i = n; i < 4; i++)
            begin
                val[8*i +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    task automatic model_store(input cmd_t cmd, input word_t addr, input word_t data);
        int i;
        for (i = 0; i < cmd_bytes(cmd); i++)
        begin
            model_mem[ram_addr_t'(addr + i)] = data[8*i +: 8];
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input reg_addr_t addr, input word_t data, input logic we);
        check("wb_rd_addr_o", 32'(wb_rd_addr_o), 32'(addr));
        check("wb_rd_data_o", wb_rd_data_o, data);
        check("wb_we_o", 32'(wb_we_o), 32'(we));
        check("fwd_valid_o", 32'(fwd_valid_o), 32'(we));
        if (we)
        begin
            check("fwd_addr_o", 32'(fwd_addr_o), 32'(addr));
            check("fwd_data_o", fwd_data_o, data);
        end
    endtask

    task automatic check_quiet();
        check("stall_o", 32'(stall_o), 32'd0);
        check("wb_we_o", 32'(wb_we_o), 32'd0);
        check("fwd_valid_o", 32'(fwd_valid_o), 32'd0);
    endtask

    task automatic run_op(input cmd_t cmd, input word_t addr, input word_t wdata,
                          input reg_addr_t rd_addr, input word_t rd_data, input logic rd_we);
        word_t exp_data;
        int    exp_stall;
        int    stall_cycles;
        exp_data  = is_load(cmd) ? model_load(cmd, addr) : rd_data;
        exp_stall = 0;
        if (is_load(cmd))
        begin
            // one extra cycle for the RAM read latency
            exp_stall = cmd_bytes(cmd) + 2;
        end
        else if (is_store(cmd))
        begin
            exp_stall = cmd_bytes(cmd) + 1;
            model_store(cmd, addr, wdata);
        end
        @(negedge clk_in);
        cmd_i        = cmd;
        mem_addr_i   = addr;
        store_data_i = wdata;
        rd_addr_i    = rd_addr;
        rd_data_i    = rd_data;
        rd_we_i      = rd_we;
        #1;
        stall_cycles = 0;
        while (stall_o === 1'b1)
        begin
            check_outputs(rd_addr, rd_data, rd_we);
            stall_cycles++;
            if (stall_cycles > exp_stall)
            begin
                check("stall_cycles", stall_cycles, exp_stall);
            end
            @(negedge clk_in);
        end
        check("stall_cycles", stall_cycles, exp_stall);
        check_outputs(rd_addr, exp_data, rd_we);
    endtask

    task automatic random_op();
        word_t r;
        word_t sel;
        cmd_t  cmd;
        word_t addr;
        word_t wdata;
        word_t rdata;
        draw(r);
        sel = r % 32'd11;
        if (sel < 32'd9)
        begin
            cmd = cmd_t'(sel);
        end
        else
        begin
            cmd = cmd_t'(32'd9 + ((r >> 8) % 32'd7));
        end
        // 64-byte window so loads land on stored bytes
        addr = 32'h0000_0400 + ((r >> 12) & 32'h0000_003f);
        draw(wdata);
        draw(rdata);
        run_op(cmd, addr, wdata, reg_addr_t'(r >> 20), rdata, r[31]);
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: run still going after %0d clock cycles", cycle_count);
        $display("RESULT: FAIL");
        $fatal(1, "simulation timed out");
    end

    initial
    begin
        int n;
        rng_state = 32'h7a15;
        for (n = 0; n < (1 << `RAM_ADDR_W); n++)
        begin
            model_mem[n] = 8'h00;
        end
        // a load with write enable must stay masked under reset
        rst_i        = 1'b1;
        cmd_i        = `CMD_LW;
        mem_addr_i   = 32'h0000_0400;
        store_data_i = 32'h0;
        rd_addr_i    = 5'd3;
        rd_data_i    = 32'h1234_5678;
        rd_we_i      = 1'b1;
        repeat (4)
        begin
            @(negedge clk_in);
            check_quiet();
        end
        rst_i   = 1'b0;
        cmd_i   = `CMD_NONE;
        rd_we_i = 1'b0;
        #1;
        check_quiet();
        @(negedge clk_in);
        check_quiet();

        // word store, then narrow loads inside it
        run_op(`CMD_SW,  32'h0000_0420, 32'h8a7f_c301, 5'd1, 32'h0, 1'b0);
        run_op(`CMD_LB,  32'h0000_0420, 32'h0, 5'd2, 32'hdead_beef, 1'b1);
        run_op(`CMD_LB,  32'h0000_0421, 32'h0, 5'd3, 32'hdead_beef, 1'b1);
        run_op(`CMD_LB,  32'h0000_0422, 32'h0, 5'd4, 32'hdead_beef, 1'b1);
        run_op(`CMD_LB,  32'h0000_0423, 32'h0, 5'd5, 32'hdead_beef, 1'b1);
        run_op(`CMD_LBU, 32'h0000_0421, 32'h0, 5'd6, 32'hdead_beef, 1'b1);
        run_op(`CMD_LBU, 32'h0000_0423, 32'h0, 5'd7, 32'hdead_beef, 1'b1);
        run_op(`CMD_LH,  32'h0000_0420, 32'h0, 5'd8, 32'hdead_beef, 1'b1);
        run_op(`CMD_LH,  32'h0000_0422, 32'h0, 5'd9, 32'hdead_beef, 1'b1);
        run_op(`CMD_LHU, 32'h0000_0422, 32'h0, 5'd10, 32'hdead_beef, 1'b1);

        for (n = NUM_DIRECTED; n < NUM_OPS; n++)
        begin
            random_op();
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
